/* verilog.f */
+incdir+hdl
hdl/matmul_pkg.sv
hdl/matmul_sequencer.sv
hdl/operand_fetch.sv
hdl/processing_element.sv
hdl/pe_array.sv
hdl/result_unloader.sv
hdl/matmul_top.sv
testbench/matmul_tb.sv

/* Bender.yml */
package:
  name: matmul

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/matmul_pkg.sv
      - hdl/matmul_sequencer.sv
      - hdl/operand_fetch.sv
      - hdl/processing_element.sv
      - hdl/pe_array.sv
      - hdl/result_unloader.sv
      - hdl/matmul_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/matmul_tb.sv

/* testbench/matmul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module matmul_tb;

    localparam int N = `MATMUL_SIZE;
    localparam int TIMEOUT_CYCLES = 40;
    localparam int FIRST_WORD_CYCLES = 15;

    logic                clk;
    logic                reset;
    logic                pe_reset;
    logic                start;
    logic                start_q = 1'b0;
    matmul_pkg::addr_t   base_a;
    matmul_pkg::addr_t   base_b;
    matmul_pkg::addr_t   base_c;
    matmul_pkg::stride_t stride_a;
    matmul_pkg::stride_t stride_b;
    matmul_pkg::stride_t stride_c;
    matmul_pkg::addr_t   a_addr;
    matmul_pkg::addr_t   b_addr;
    matmul_pkg::vec_t    a_data;
    matmul_pkg::vec_t    b_data;
    matmul_pkg::vec_t    c_data;
    matmul_pkg::addr_t   c_addr;
    logic                c_data_available;
    logic                done;

    // Operands, running reference and the memory images built from them
    matmul_pkg::elem_t a_mat [N][N];
    matmul_pkg::elem_t b_mat [N][N];
    matmul_pkg::elem_t c_ref [N][N];
    matmul_pkg::vec_t  a_mem [N];
    matmul_pkg::vec_t  b_mem [N];
    matmul_pkg::addr_t a_seen [$];
    matmul_pkg::addr_t b_seen [$];
    integer            seed = 40251;
    int                errors = 0;
    int                checks = 0;

    matmul_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Memory models with one cycle of read latency

    function automatic int word_index(input matmul_pkg::addr_t addr,
                                      input matmul_pkg::addr_t base,
                                      input matmul_pkg::stride_t stride);
        matmul_pkg::addr_t offset;
        offset = addr - base;
        if (stride == '0 || offset % stride != 0 || offset / stride >= N)
            return -1;
        return int'(offset / stride);
    endfunction

    always @(posedge clk)
    begin
        int  ia;
        int  ib;
        logic active;
        // The first cycle of start still shows the reset address
        active = start && start_q;
        start_q <= start;
        ia = word_index(a_addr, base_a, stride_a);
        ib = word_index(b_addr, base_b, stride_b);
        if (active)
        begin
            if (ia < 0 || ib < 0)
            begin
                errors++;
                $display("Read outside the matrix at %0t ns: a_addr %0d, b_addr %0d",
                         $time, a_addr, b_addr);
            end
            if (a_seen.size() == 0 || a_seen[$] != a_addr)
                a_seen.push_back(a_addr);
            if (b_seen.size() == 0 || b_seen[$] != b_addr)
                b_seen.push_back(b_addr);
        end
        a_data <= #1 (active && ia >= 0) ? a_mem[ia] : '0;
        b_data <= #1 (active && ib >= 0) ? b_mem[ib] : '0;
    end

    ////////////////////////////////////////
    // Compare tasks

    task automatic check_vec(input matmul_pkg::vec_t got, input matmul_pkg::vec_t exp,
                             input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input matmul_pkg::addr_t got, input matmul_pkg::addr_t exp,
                              input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic step_cycle;
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // Operand preparation and reference model

    task automatic randomize_operands(input bit identity_a);
        for (int i = 0; i < N; i++)
            for (int j = 0; j < N; j++)
            begin
                a_mat[i][j] = identity_a ? matmul_pkg::elem_t'(i == j) : $random(seed);
                b_mat[i][j] = $random(seed);
            end
        // Word k holds column k of A and row k of B
        for (int k = 0; k < N; k++)
            for (int l = 0; l < N; l++)
            begin
                a_mem[k][l*`MATMUL_DWIDTH +: `MATMUL_DWIDTH] = a_mat[l][k];
                b_mem[k][l*`MATMUL_DWIDTH +: `MATMUL_DWIDTH] = b_mat[k][l];
            end
    endtask

    task automatic add_reference;
        matmul_pkg::elem_t sum;
        for (int i = 0; i < N; i++)
            for (int j = 0; j < N; j++)
            begin
                sum = c_ref[i][j];
                for (int k = 0; k < N; k++)
                    sum = sum + a_mat[i][k] * b_mat[k][j];
                c_ref[i][j] = sum;
            end
    endtask

    task automatic clear_accumulators;
        pe_reset = 1'b1;
        step_cycle;
        pe_reset = 1'b0;
        for (int i = 0; i < N; i++)
            for (int j = 0; j < N; j++)
                c_ref[i][j] = '0;
    endtask

    ////////////////////////////////////////
    // One operation from start to the end of the result burst

    task automatic run_operation(input matmul_pkg::addr_t ba, input matmul_pkg::stride_t sa,
                                 input matmul_pkg::addr_t bb, input matmul_pkg::stride_t sb,
                                 input matmul_pkg::addr_t bc, input matmul_pkg::stride_t sc);
        int               cycles;
        matmul_pkg::vec_t expected;
        add_reference;
        base_a = ba;
        base_b = bb;
        base_c = bc;
        stride_a = sa;
        stride_b = sb;
        stride_c = sc;
        a_seen.delete();
        b_seen.delete();
        // The fetch address registers load base minus stride while start is low
        step_cycle;
        start = 1'b1;
        cycles = 0;
        while (!c_data_available && cycles < TIMEOUT_CYCLES)
        begin
            step_cycle;
            cycles++;
            check_bit(done, 1'b0, "done before the results");
        end
        if (!c_data_available)
        begin
            errors++;
            $display("Timed out waiting for c_data_available at %0t ns", $time);
            start = 1'b0;
            return;
        end
        check_bit(cycles == FIRST_WORD_CYCLES, 1'b1, "first word latency of 15 cycles");
        for (int k = 0; k < N; k++)
        begin
            for (int i = 0; i < N; i++)
                expected[i*`MATMUL_DWIDTH +: `MATMUL_DWIDTH] = c_ref[i][k];
            check_bit(c_data_available, 1'b1, "c_data_available");
            check_vec(c_data, expected, $sformatf("c_data word %0d", k));
            check_addr(c_addr, bc + matmul_pkg::addr_t'(k * sc), $sformatf("c_addr %0d", k));
            check_bit(done, k == N - 1, $sformatf("done at word %0d", k));
            step_cycle;
        end
        check_bit(c_data_available, 1'b0, "c_data_available after the burst");
        check_bit(done, 1'b0, "done after the burst");
        start = 1'b0;
        step_cycle;
        check_bit(a_seen.size() == N, 1'b1, "four distinct A addresses");
        check_bit(b_seen.size() == N, 1'b1, "four distinct B addresses");
        for (int k = 0; k < N && k < a_seen.size(); k++)
            check_addr(a_seen[k], ba + matmul_pkg::addr_t'(k * sa), $sformatf("a_addr %0d", k));
        for (int k = 0; k < N && k < b_seen.size(); k++)
            check_addr(b_seen[k], bb + matmul_pkg::addr_t'(k * sb), $sformatf("b_addr %0d", k));
    endtask

    ////////////////////////////////////////
    // Directed tests

    task automatic idle_after_reset;
        repeat (5)
        begin
            step_cycle;
            check_bit(done, 1'b0, "done while idle");
            check_bit(c_data_available, 1'b0, "c_data_available while idle");
        end
    endtask

    task automatic identity_times_b;
        clear_accumulators;
        randomize_operands(1'b1);
        run_operation(11'd16, 8'd1, 11'd64, 8'd1, 11'd128, 8'd1);
    endtask

    task automatic product_after_clear;
        clear_accumulators;
        randomize_operands(1'b0);
        run_operation(11'd200, 8'd3, 11'd300, 8'd5, 11'd500, 8'd7);
    endtask

    // No pe_reset here, so C builds on the previous result
    task automatic product_on_top;
        randomize_operands(1'b0);
        run_operation(11'd40, 8'd2, 11'd700, 8'd9, 11'd1000, 8'd4);
    endtask

    initial
    begin
        reset = 1'b1;
        pe_reset = 1'b0;
        start = 1'b0;
        base_a = '0;
        base_b = '0;
        base_c = '0;
        stride_a = 8'd1;
        stride_b = 8'd1;
        stride_c = 8'd1;
        a_data = '0;
        b_data = '0;
        repeat (3) step_cycle;
        reset = 1'b0;
        idle_after_reset;
        identity_times_b;
        product_after_clear;
        product_on_top;
        $display("Checks run: %0d, errors counted: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/matmul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module matmul_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                pe_reset,
    input  logic                start,
    input  matmul_pkg::addr_t   base_a,
    input  matmul_pkg::addr_t   base_b,
    input  matmul_pkg::addr_t   base_c,
    input  matmul_pkg::stride_t stride_a,
    input  matmul_pkg::stride_t stride_b,
    input  matmul_pkg::stride_t stride_c,
    output matmul_pkg::addr_t   a_addr,
    output matmul_pkg::addr_t   b_addr,
    input  matmul_pkg::vec_t    a_data,
    input  matmul_pkg::vec_t    b_data,
    output matmul_pkg::vec_t    c_data,
    output matmul_pkg::addr_t   c_addr,
    output logic                c_data_available,
    output logic                done
);

    logic             fetch_en;
    logic             capture;
    matmul_pkg::vec_t a_skewed;
    matmul_pkg::vec_t b_skewed;
    matmul_pkg::vec_t c_col0;
    matmul_pkg::vec_t c_col1;
    matmul_pkg::vec_t c_col2;
    matmul_pkg::vec_t c_col3;

    ////////////////////////////////////////
    // Schedule

    matmul_sequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .fetch_en (fetch_en),
        .capture  (capture),
        .done     (done)
    );

    ////////////////////////////////////////
    // Operand fetch, A by column and B by row

    operand_fetch u_fetch_a (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .fetch_en (fetch_en),
        .base     (base_a),
        .stride   (stride_a),
        .addr     (a_addr),
        .mem_data (a_data),
        .skewed   (a_skewed)
    );

    operand_fetch u_fetch_b (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .fetch_en (fetch_en),
        .base     (base_b),
        .stride   (stride_b),
        .addr     (b_addr),
        .mem_data (b_data),
        .skewed   (b_skewed)
    );

    ////////////////////////////////////////
    // Mesh and result path

    pe_array u_mesh (
        .clk      (clk),
        .reset    (reset),
        .pe_reset (pe_reset),
        .a_edge   (a_skewed),
        .b_edge   (b_skewed),
        .c_col0   (c_col0),
        .c_col1   (c_col1),
        .c_col2   (c_col2),
        .c_col3   (c_col3)
    );

    result_unloader u_unloader (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .capture          (capture),
        .done             (done),
        .c_col0           (c_col0),
        .c_col1           (c_col1),
        .c_col2           (c_col2),
        .c_col3           (c_col3),
        .base_c           (base_c),
        .stride_c         (stride_c),
        .c_data           (c_data),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

`default_nettype wire

/* hdl/result_unloader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module result_unloader (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                capture,
    input  logic                done,
    input  matmul_pkg::vec_t    c_col0,
    input  matmul_pkg::vec_t    c_col1,
    input  matmul_pkg::vec_t    c_col2,
    input  matmul_pkg::vec_t    c_col3,
    input  matmul_pkg::addr_t   base_c,
    input  matmul_pkg::stride_t stride_c,
    output matmul_pkg::vec_t    c_data,
    output matmul_pkg::addr_t   c_addr,
    output logic                c_data_available
);

    matmul_pkg::vec_t hold [`MATMUL_SIZE-1];

    ////////////////////////////////////////
    // Output word, address and valid

    always_ff @(posedge clk)
    begin
        if (reset || !start)
        begin
            c_data           <= '0;
            c_addr           <= base_c;
            c_data_available <= 1'b0;
        end
        else if (capture)
        begin
            c_data           <= c_col0;
            c_addr           <= base_c;
            c_data_available <= 1'b1;
        end
        else if (done)
        begin
            c_data           <= '0;
            c_data_available <= 1'b0;
        end
        else if (c_data_available)
        begin
            c_data <= hold[0];
            c_addr <= c_addr + matmul_pkg::addr_t'(stride_c);
        end
    end

    // Columns 1 to 3 wait here and move down one slot per output word
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            hold[0] <= c_col1;
            hold[1] <= c_col2;
            hold[2] <= c_col3;
        end
        else
        begin
            hold[0] <= hold[1];
            hold[1] <= hold[2];
            hold[2] <= '0;
        end
    end

    burst_length: assert property (
        @(posedge clk) disable iff (reset || !start)
        $rose(c_data_available) |-> c_data_available[*`MATMUL_SIZE] ##1 !c_data_available);

endmodule

`default_nettype wire

/* hdl/pe_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module pe_array (
    input  logic             clk,
    input  logic             reset,
    input  logic             pe_reset,
    input  matmul_pkg::vec_t a_edge,
    input  matmul_pkg::vec_t b_edge,
    output matmul_pkg::vec_t c_col0,
    output matmul_pkg::vec_t c_col1,
    output matmul_pkg::vec_t c_col2,
    output matmul_pkg::vec_t c_col3
);

    logic              cell_reset;
    matmul_pkg::elem_t a_link [`MATMUL_SIZE][`MATMUL_SIZE+1];
    matmul_pkg::elem_t b_link [`MATMUL_SIZE+1][`MATMUL_SIZE];
    matmul_pkg::elem_t acc    [`MATMUL_SIZE][`MATMUL_SIZE];
    matmul_pkg::vec_t  col    [`MATMUL_SIZE];

    // pe_reset clears the accumulators between independent operations
    assign cell_reset = reset | pe_reset;

    ////////////////////////////////////////
    // Mesh, A flows right and B flows down

    for (genvar r = 0; r < `MATMUL_SIZE; r++)
    begin : g_row
        assign a_link[r][0] = a_edge[r*`MATMUL_DWIDTH +: `MATMUL_DWIDTH];
        assign b_link[0][r] = b_edge[r*`MATMUL_DWIDTH +: `MATMUL_DWIDTH];

        for (genvar c = 0; c < `MATMUL_SIZE; c++)
        begin : g_col
            processing_element u_pe (
                .clk   (clk),
                .reset (cell_reset),
                .in_a  (a_link[r][c]),
                .in_b  (b_link[r][c]),
                .out_a (a_link[r][c+1]),
                .out_b (b_link[r+1][c]),
                .acc   (acc[r][c])
            );
        end
    end

    // Row r of each column lands in lane r
    always_comb
    begin
        for (int c = 0; c < `MATMUL_SIZE; c++)
            for (int r = 0; r < `MATMUL_SIZE; r++)
                col[c][r*`MATMUL_DWIDTH +: `MATMUL_DWIDTH] = acc[r][c];
    end

    assign c_col0 = col[0];
    assign c_col1 = col[1];
    assign c_col2 = col[2];
    assign c_col3 = col[3];

endmodule

`default_nettype wire

/* hdl/processing_element.sv */
`timescale 1ns/1ps
`default_nettype none

module processing_element (
    input  logic              clk,
    input  logic              reset,
    input  matmul_pkg::elem_t in_a,
    input  matmul_pkg::elem_t in_b,
    output matmul_pkg::elem_t out_a,
    output matmul_pkg::elem_t out_b,
    output matmul_pkg::elem_t acc
);

    matmul_pkg::elem_t prod;

    // The forwarding registers double as the MAC input stage, so the three
    // stages are operand capture, multiply and accumulate
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_a <= '0;
            out_b <= '0;
            prod  <= '0;
            acc   <= '0;
        end
        else
        begin
            out_a <= in_a;
            out_b <= in_b;
            prod  <= out_a * out_b;
            // Sum wraps at the operand width
            acc   <= acc + prod;
        end
    end

endmodule

`default_nettype wire

/* hdl/operand_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module operand_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                fetch_en,
    input  matmul_pkg::addr_t   base,
    input  matmul_pkg::stride_t stride,
    output matmul_pkg::addr_t   addr,
    input  matmul_pkg::vec_t    mem_data,
    output matmul_pkg::vec_t    skewed
);

    logic                   mem_access;
    logic                   data_valid;
    matmul_pkg::cycle_cnt_t access_cnt;
    matmul_pkg::vec_t       word;
    matmul_pkg::elem_t      lane_out [`MATMUL_SIZE];

    ////////////////////////////////////////
    // Address generation

    // Starting one stride low lets the first fetch cycle issue base itself
    always_ff @(posedge clk)
    begin
        if (reset || !start)
        begin
            addr       <= base - matmul_pkg::addr_t'(stride);
            mem_access <= 1'b0;
            access_cnt <= '0;
        end
        else
        begin
            mem_access <= fetch_en;
            if (fetch_en)
                addr <= addr + matmul_pkg::addr_t'(stride);
            if (mem_access)
                access_cnt <= access_cnt + 1'b1;
            else
                access_cnt <= '0;
        end
    end

    // Read data lags the address by one cycle
    assign data_valid = (access_cnt != '0);
    assign word = data_valid ? mem_data : '0;

    ////////////////////////////////////////
    // Lane skew, lane i delayed by i cycles

    for (genvar lane = 0; lane < `MATMUL_SIZE; lane++)
    begin : g_lane
        if (lane == 0)
        begin : g_direct
            assign lane_out[0] = word[`MATMUL_DWIDTH-1:0];
        end
        else
        begin : g_delay
            matmul_pkg::elem_t pipe [lane];

            always_ff @(posedge clk)
            begin
                if (reset || !start)
                begin
                    for (int s = 0; s < lane; s++)
                        pipe[s] <= '0;
                end
                else
                begin
                    pipe[0] <= word[lane*`MATMUL_DWIDTH +: `MATMUL_DWIDTH];
                    for (int s = 1; s < lane; s++)
                        pipe[s] <= pipe[s-1];
                end
            end

            assign lane_out[lane] = pipe[lane-1];
        end
    end

    always_comb
    begin
        for (int l = 0; l < `MATMUL_SIZE; l++)
            skewed[l*`MATMUL_DWIDTH +: `MATMUL_DWIDTH] = lane_out[l];
    end

    addr_moves_on_fetch: assert property (
        @(posedge clk) disable iff (reset)
        $past(start) && !$past(reset) && !$past(fetch_en) |-> $stable(addr));

endmodule

`default_nettype wire

/* hdl/matmul_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module matmul_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic fetch_en,
    output logic capture,
    output logic done
);

    matmul_pkg::cycle_cnt_t cnt;

    // The count saturates so that a long start level cannot fire done twice
    always_ff @(posedge clk)
    begin
        if (reset || !start)
        begin
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            if (cnt != '1)
                cnt <= cnt + 1'b1;
            done <= (cnt == `MATMUL_DONE_CNT);
        end
    end

    assign fetch_en = start && (cnt < `MATMUL_SIZE);

    // Last product has left the MAC pipeline of the far corner cell
    assign capture = (cnt == `MATMUL_CAPTURE_CNT);

    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done);

endmodule

`default_nettype wire

/* hdl/matmul_pkg.sv */
`default_nettype none

`include "matmul_consts.svh"

package matmul_pkg;

    typedef logic [`MATMUL_DWIDTH-1:0] elem_t;
    // One memory word, lane 0 in the low bits
    typedef logic [`MATMUL_SIZE*`MATMUL_DWIDTH-1:0] vec_t;
    typedef logic [`MATMUL_AWIDTH-1:0] addr_t;
    typedef logic [`MATMUL_STRIDE_WIDTH-1:0] stride_t;
    typedef logic [`MATMUL_CNT_WIDTH-1:0] cycle_cnt_t;

endpackage

`default_nettype wire

/* hdl/matmul_consts.svh */
`ifndef MATMUL_CONSTS_SVH
`define MATMUL_CONSTS_SVH

// Datapath and memory widths
`define MATMUL_DWIDTH 8
`define MATMUL_AWIDTH 11
`define MATMUL_STRIDE_WIDTH 8

// Mesh geometry and MAC depth
`define MATMUL_SIZE 4
`define MATMUL_MAC_STAGES 3

// Schedule counter and the counts at which C is complete and done rises
`define MATMUL_CNT_WIDTH 8
`define MATMUL_CAPTURE_CNT (3 * `MATMUL_SIZE - 1 + `MATMUL_MAC_STAGES)
`define MATMUL_DONE_CNT (`MATMUL_CAPTURE_CNT + `MATMUL_MAC_STAGES)

`endif
